// File: include/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Datapath width of the execute unit
`define ALU_WIDTH    16

// Register file depth
`define ALU_NREGS    8

// Register index width, log2 of ALU_NREGS
`define ALU_REG_BITS 3

// Opcode field width in the instruction word
`define ALU_OP_BITS  4

// Immediate field width, zero-extended to ALU_WIDTH
`define ALU_IMM_BITS 5

// Instruction word layout, MSB first
//   register form   imm=0 | opcode | dest | src_a | src_b | pad
//   immediate form  imm=1 | opcode | dest | src_a | imm
// 1 + 4 + 3 + 3 + 3 + 2 = 16
// 1 + 4 + 3 + 3 + 5     = 16

`endif

// File: hdl/alu_pkg.sv
`include "alu_config.svh"

package alu_pkg;

  // Four-bit opcode encoding
  typedef enum logic [`ALU_OP_BITS-1:0] {
    OP_ADD = 4'b0000,
    OP_ADC = 4'b0001, // Uses stored carry
    OP_SUB = 4'b0010,
    OP_SBC = 4'b0011, // Uses stored carry as borrow in
    OP_MUL = 4'b0100, // Low half only
    OP_DIV = 4'b0101, // Multi-cycle in the divider block
    OP_AND = 4'b0110,
    OP_OR  = 4'b0111,
    OP_XOR = 4'b1000,
    OP_SHL = 4'b1001,
    OP_SHR = 4'b1010,
    OP_NOT = 4'b1011, // Operand a
    OP_CMP = 4'b1100, // Flags only
    OP_INC = 4'b1101, // Operand a
    OP_DEC = 4'b1110, // Operand a
    OP_MOV = 4'b1111  // Operand b
  } alu_op_e;

  // Bit 0 carry up to bit 3 zero
  typedef struct packed {
    logic zero;
    logic overflow;
    logic sign;
    logic carry;
  } alu_flags_t;

  // Register form with both sources from the register file
  typedef struct packed {
    logic                     is_imm; // 0 here
    alu_op_e                  opcode;
    logic [`ALU_REG_BITS-1:0] dest;
    logic [`ALU_REG_BITS-1:0] src_a;
    logic [`ALU_REG_BITS-1:0] src_b;
    logic [1:0]               pad;
  } instr_reg_t;

  // Immediate form where operand b is a small unsigned constant
  typedef struct packed {
    logic                     is_imm; // 1 here
    alu_op_e                  opcode;
    logic [`ALU_REG_BITS-1:0] dest;
    logic [`ALU_REG_BITS-1:0] src_a;
    logic [`ALU_IMM_BITS-1:0] imm;
  } instr_imm_t;

  // Bit 15 selects the view
  typedef union packed {
    instr_reg_t r;
    instr_imm_t i;
  } instr_u;

  // ALU input bundle
  typedef struct packed {
    alu_op_e                op;
    logic [`ALU_WIDTH-1:0]  op_a;
    logic [`ALU_WIDTH-1:0]  op_b;
    logic                   cin;
  } alu_operands_t;

endpackage

// File: hdl/alu_core.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module alu_core (
  input  alu_pkg::alu_operands_t  operands,
  output logic [`ALU_WIDTH-1:0]   result,
  output alu_pkg::alu_flags_t     flags
);
  import alu_pkg::*;

  logic [`ALU_WIDTH:0]   wide;    // Extra MSB holds carry or borrow
  logic [`ALU_WIDTH-1:0] rhs;     // Second add/sub operand for overflow
  logic [`ALU_WIDTH-1:0] mul_lo;  // Low half of product
  logic                  is_add;  // Add-type op
  logic                  is_sub;  // Sub-type op
  logic                  a_msb;
  logic                  rhs_msb;
  logic                  res_msb;

  always_comb begin
    rhs    = operands.op_b;
    mul_lo = operands.op_a * operands.op_b; // Truncated to W by context
    is_add = 1'b0;
    is_sub = 1'b0;
    wide   = '0;
    case (operands.op)
      OP_ADD: begin
        wide   = {1'b0, operands.op_a} + {1'b0, operands.op_b};
        is_add = 1'b1;
      end
      OP_ADC: begin
        wide   = {1'b0, operands.op_a} + {1'b0, operands.op_b} + operands.cin;
        is_add = 1'b1;
      end
      OP_SUB: begin
        wide   = {1'b0, operands.op_a} - {1'b0, operands.op_b}; // MSB set on borrow
        is_sub = 1'b1;
      end
      OP_SBC: begin
        wide   = {1'b0, operands.op_a} - {1'b0, operands.op_b} - operands.cin;
        is_sub = 1'b1;
      end
      OP_MUL: wide = {1'b0, mul_lo};
      OP_DIV: wide = '0;              // Quotient taken from divider instead
      OP_AND: wide = {1'b0, operands.op_a & operands.op_b};
      OP_OR:  wide = {1'b0, operands.op_a | operands.op_b};
      OP_XOR: wide = {1'b0, operands.op_a ^ operands.op_b};
      // Shift amount >= W clears the word
      OP_SHL: wide = {1'b0, operands.op_a << operands.op_b};
      OP_SHR: wide = {1'b0, operands.op_a >> operands.op_b};
      OP_NOT: wide = {1'b0, ~operands.op_a};
      OP_CMP: begin
        wide   = {1'b0, operands.op_a} - {1'b0, operands.op_b};
        is_sub = 1'b1;
      end
      OP_INC: begin
        rhs    = `ALU_WIDTH'(1);
        wide   = {1'b0, operands.op_a} + 1'b1;
        is_add = 1'b1;
      end
      OP_DEC: begin
        rhs    = `ALU_WIDTH'(1);
        wide   = {1'b0, operands.op_a} - 1'b1; // Borrow when a is zero
        is_sub = 1'b1;
      end
      OP_MOV: wide = {1'b0, operands.op_b};
      default: wide = '0;
    endcase
  end

  assign result  = wide[`ALU_WIDTH-1:0];
  assign a_msb   = operands.op_a[`ALU_WIDTH-1];
  assign rhs_msb = rhs[`ALU_WIDTH-1];
  assign res_msb = result[`ALU_WIDTH-1];

  always_comb begin
    flags.carry = (is_add | is_sub) & wide[`ALU_WIDTH];
    flags.sign  = res_msb;
    // Signed overflow from operand signs vs result sign
    if (is_add)
      flags.overflow = (a_msb == rhs_msb) && (res_msb != a_msb);
    else if (is_sub)
      flags.overflow = (a_msb != rhs_msb) && (res_msb != a_msb);
    else
      flags.overflow = 1'b0;
    flags.zero  = ~|result;
  end

endmodule

// File: hdl/divider_seq.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module divider_seq (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  logic [`ALU_WIDTH-1:0]  dividend,
  input  logic [`ALU_WIDTH-1:0]  divisor,
  output logic                   done,
  output logic [`ALU_WIDTH-1:0]  quotient
);

  logic                               busy;
  logic [$clog2(`ALU_WIDTH+1)-1:0]    count;   // Quotient bits still to produce
  logic [`ALU_WIDTH-1:0]              rem;     // Partial remainder
  logic [`ALU_WIDTH-1:0]              quo;     // Dividend shifts out, quotient shifts in
  logic [`ALU_WIDTH-1:0]              dvsr;
  logic [`ALU_WIDTH:0]                shifted; // Remainder with next dividend bit
  logic [`ALU_WIDTH:0]                diff;    // Trial subtraction

  assign shifted = {rem, quo[`ALU_WIDTH-1]};
  assign diff    = shifted - {1'b0, dvsr};

  // W iterations then a single done pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        count <= `ALU_WIDTH;
      end else if (busy) begin
        count <= count - 1'b1;
        if (count == 1) begin // Last bit this cycle
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (start) begin
      rem  <= '0;
      quo  <= dividend;
      dvsr <= divisor;
    end else if (busy) begin
      // Restore when trial goes negative
      rem <= diff[`ALU_WIDTH] ? shifted[`ALU_WIDTH-1:0] : diff[`ALU_WIDTH-1:0];
      quo <= {quo[`ALU_WIDTH-2:0], ~diff[`ALU_WIDTH]}; // Zero divisor gives all ones
    end
  end

  assign quotient = quo;

  // Controller must wait for done before a new start
  start_idle_chk: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
    else $error("divider_seq: start while busy");

  // One done pulse exactly W+1 cycles after start
  done_pulse_chk: assert property (
    @(posedge clk) disable iff (!rst_n) start |-> ##(`ALU_WIDTH+1) done ##1 !done)
    else $error("divider_seq: done not a single pulse W+1 cycles after start");

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module reg_file (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`ALU_REG_BITS-1:0]  rd_addr_a,
  input  logic [`ALU_REG_BITS-1:0]  rd_addr_b,
  output logic [`ALU_WIDTH-1:0]     rd_data_a,
  output logic [`ALU_WIDTH-1:0]     rd_data_b,
  input  logic                      wr_en,
  input  logic [`ALU_REG_BITS-1:0]  wr_addr,
  input  logic [`ALU_WIDTH-1:0]     wr_data
);

  logic [`ALU_WIDTH-1:0] regs [`ALU_NREGS]; // General purpose registers

  // Single write port, all registers cleared by reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regs <= '{default: '0};
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Async reads, old value seen during the write cycle
  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

  wr_addr_known_chk: assert property (
    @(posedge clk) disable iff (!rst_n) wr_en |-> !$isunknown(wr_addr))
    else $error("reg_file: write with unknown address");

endmodule

// File: hdl/exec_ctrl.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module exec_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req,
  input  alu_pkg::instr_u           instr,
  output logic                      ack,
  output logic [`ALU_WIDTH-1:0]     result,
  output alu_pkg::alu_flags_t       flags,
  output logic [`ALU_REG_BITS-1:0]  rd_addr_a,
  output logic [`ALU_REG_BITS-1:0]  rd_addr_b,
  input  logic [`ALU_WIDTH-1:0]     rd_data_a,
  input  logic [`ALU_WIDTH-1:0]     rd_data_b,
  output logic                      wr_en,
  output logic [`ALU_REG_BITS-1:0]  wr_addr,
  output logic [`ALU_WIDTH-1:0]     wr_data,
  output alu_pkg::alu_operands_t    alu_operands,
  input  logic [`ALU_WIDTH-1:0]     alu_result,
  input  alu_pkg::alu_flags_t       alu_flags,
  output logic                      div_start,
  input  logic                      div_done,
  input  logic [`ALU_WIDTH-1:0]     div_quotient
);
  import alu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,     // Waiting for req
    ST_EXEC,     // Operands read and ALU result valid
    ST_DIV_WAIT, // Divider running
    ST_ACK       // Raise ack, then wait for req low
  } state_e;

  state_e     state;
  instr_u     instr_q;   // Captured command
  alu_op_e    op;
  alu_flags_t div_flags;
  logic       is_div;
  logic       is_cmp;

  // Opcode, dest and src_a share positions in both views
  assign op     = instr_q.r.opcode;
  assign is_div = (op == OP_DIV);
  assign is_cmp = (op == OP_CMP);

  assign rd_addr_a = instr_q.r.src_a;
  assign rd_addr_b = instr_q.r.src_b; // Unused in immediate form

  // Operand b from register or zero-extended immediate
  always_comb begin
    alu_operands.op   = op;
    alu_operands.op_a = rd_data_a;
    alu_operands.op_b = instr_q.r.is_imm ?
                        {{(`ALU_WIDTH-`ALU_IMM_BITS){1'b0}}, instr_q.i.imm} : rd_data_b;
    alu_operands.cin  = flags.carry; // Stored carry for adc/sbc
  end

  assign div_start = (state == ST_EXEC) && is_div; // Divider latches operands here

  // Division sets only sign and zero
  always_comb begin
    div_flags          = '0;
    div_flags.sign     = div_quotient[`ALU_WIDTH-1];
    div_flags.zero     = ~|div_quotient;
  end

  // Combinational writeback lands on the same edge as flags
  assign wr_en   = ((state == ST_EXEC) && !is_div && !is_cmp) ||
                   ((state == ST_DIV_WAIT) && div_done);
  assign wr_addr = instr_q.r.dest;
  assign wr_data = (state == ST_DIV_WAIT) ? div_quotient : alu_result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      ack   <= 1'b0;
      flags <= '0;
    end else begin
      case (state)
        ST_IDLE: if (req) state <= ST_EXEC;
        ST_EXEC: begin
          if (is_div) begin
            state <= ST_DIV_WAIT;
          end else begin
            flags <= alu_flags; // cmp updates flags too
            state <= ST_ACK;
          end
        end
        ST_DIV_WAIT: begin
          if (div_done) begin
            flags <= div_flags;
            state <= ST_ACK;
          end
        end
        ST_ACK: begin
          if (!ack) begin
            ack <= 1'b1;        // One cycle after result registered
          end else if (!req) begin
            ack   <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Captured command and result
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req)
      instr_q <= instr;
    if (state == ST_EXEC && !is_div)
      result <= alu_result;
    else if (state == ST_DIV_WAIT && div_done)
      result <= div_quotient;
  end

  // Host may drop req as soon as it sees ack
  ack_needs_req_chk: assert property (
    @(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req))
    else $error("exec_ctrl: ack raised without req");

  // Host keeps instr stable until ack
  instr_stable_chk: assert property (
    @(posedge clk) disable iff (!rst_n) (req && !ack) ##1 req |-> $stable(instr))
    else $error("exec_ctrl: instr changed while req pending");

endmodule

// File: hdl/alu_subsys_top.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module alu_subsys_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  alu_pkg::instr_u       instr,
  output logic                  ack,
  output logic [`ALU_WIDTH-1:0] result,
  output alu_pkg::alu_flags_t   flags
);
  import alu_pkg::*;

  logic [`ALU_REG_BITS-1:0] rd_addr_a;
  logic [`ALU_REG_BITS-1:0] rd_addr_b;
  logic [`ALU_WIDTH-1:0]    rd_data_a;
  logic [`ALU_WIDTH-1:0]    rd_data_b;
  logic                     wr_en;
  logic [`ALU_REG_BITS-1:0] wr_addr;
  logic [`ALU_WIDTH-1:0]    wr_data;
  alu_operands_t            alu_operands; // Also feeds divider operands
  logic [`ALU_WIDTH-1:0]    alu_result;
  alu_flags_t               alu_flags;
  logic                     div_start;
  logic                     div_done;
  logic [`ALU_WIDTH-1:0]    div_quotient;

  exec_ctrl exec_ctrl_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .instr        (instr),
    .ack          (ack),
    .result       (result),
    .flags        (flags),
    .rd_addr_a    (rd_addr_a),
    .rd_addr_b    (rd_addr_b),
    .rd_data_a    (rd_data_a),
    .rd_data_b    (rd_data_b),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .alu_operands (alu_operands),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags),
    .div_start    (div_start),
    .div_done     (div_done),
    .div_quotient (div_quotient)
  );

  reg_file reg_file_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  alu_core alu_core_inst (
    .operands (alu_operands),
    .result   (alu_result),
    .flags    (alu_flags)
  );

  // Dividend is op_a, divisor op_b
  divider_seq divider_seq_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (div_start),
    .dividend (alu_operands.op_a),
    .divisor  (alu_operands.op_b),
    .done     (div_done),
    .quotient (div_quotient)
  );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk
);

  // 4 ns period, starts low
  initial begin
    clk = 1'b0;
  end

  always begin
    #2 clk = ~clk; // Half period
  end

endmodule

// File: verification/alu_subsys_tb.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module alu_subsys_tb;
  import alu_pkg::*;

  localparam int     W        = `ALU_WIDTH;
  localparam longint U_MAX    = (longint'(1) << W) - 1;      // Largest unsigned word
  localparam longint S_MAX    = (longint'(1) << (W - 1)) - 1;
  localparam longint S_MIN    = -(longint'(1) << (W - 1));
  localparam int     N_LOAD   = 3 * `ALU_NREGS;              // mov, add, read per register
  localparam int     N_RAND   = 400;
  localparam int     N_ROUNDS = 12;                          // Carry chaining rounds
  localparam int     N_CHAIN  = 7 * N_ROUNDS;
  localparam int     N_DIV    = 24;
  localparam int     N_INSTR  = N_LOAD + N_RAND + N_CHAIN + N_DIV;
  localparam int     TIMEOUT_CYCLES = N_INSTR * (W + 8) + 100;

  // Expected response of one instruction
  typedef struct packed {
    alu_flags_t      flags;
    logic [W-1:0]    value;
  } prediction_t;

  logic         clk;
  logic         rst_n;
  logic         req;
  instr_u       instr;
  logic         ack;
  logic [W-1:0] result;
  alu_flags_t   flags;

  logic [W-1:0] regs_m [`ALU_NREGS]; // Register mirror
  alu_flags_t   flags_m;             // Flag mirror
  integer       seed;
  int           cycle_count;

  tb_clock_gen clock_gen_inst (
    .clk (clk)
  );

  alu_subsys_top alu_subsys_top_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .instr  (instr),
    .ack    (ack),
    .result (result),
    .flags  (flags)
  );

  // Result and flag rules, worked out in wide signed arithmetic
  function automatic prediction_t predict(input alu_op_e op, input logic [W-1:0] a,
                                          input logic [W-1:0] b, input logic cin);
    prediction_t p;
    longint      ua;
    longint      ub;
    longint      sa;
    longint      sb;
    longint      c;
    longint      full;
    longint      sfull;
    logic        arith;
    ua    = a;             // Zero extended
    ub    = b;
    sa    = $signed(a);    // Sign extended
    sb    = $signed(b);
    c     = (op == OP_ADC || op == OP_SBC) ? cin : 0;
    full  = 0;
    sfull = 0;
    arith = 1'b0;
    p     = '0;
    if (op == OP_INC || op == OP_DEC) begin
      ub = 1;              // Implicit second operand
      sb = 1;
    end
    case (op)
      OP_ADD, OP_ADC, OP_INC: begin
        full          = ua + ub + c;
        sfull         = sa + sb + c;
        p.flags.carry = (full > U_MAX);
        arith         = 1'b1;
      end
      OP_SUB, OP_SBC, OP_CMP, OP_DEC: begin
        full          = ua - ub - c;
        sfull         = sa - sb - c;
        p.flags.carry = (full < 0); // Borrow
        arith         = 1'b1;
      end
      OP_MUL: p.value = (ua * ub) & U_MAX;
      OP_DIV: p.value = (ub == 0) ? U_MAX : ua / ub;
      OP_AND: p.value = a & b;
      OP_OR:  p.value = a | b;
      OP_XOR: p.value = a ^ b;
      OP_SHL: p.value = (ub >= W) ? '0 : (ua << ub) & U_MAX;
      OP_SHR: p.value = (ub >= W) ? '0 : ua >> ub;
      OP_NOT: p.value = ~a;
      default: p.value = b; // mov
    endcase
    if (arith) begin
      p.value            = full & U_MAX;
      p.flags.overflow   = (sfull > S_MAX) || (sfull < S_MIN);
    end
    p.flags.sign = p.value[W-1];
    p.flags.zero = (p.value == '0);
    return p;
  endfunction

  function automatic instr_u make_reg(input alu_op_e op, input logic [`ALU_REG_BITS-1:0] dest,
                                      input logic [`ALU_REG_BITS-1:0] src_a,
                                      input logic [`ALU_REG_BITS-1:0] src_b);
    instr_u u;
    u          = '0;
    u.r.is_imm = 1'b0;
    u.r.opcode = op;
    u.r.dest   = dest;
    u.r.src_a  = src_a;
    u.r.src_b  = src_b;
    return u;
  endfunction

  function automatic instr_u make_imm(input alu_op_e op, input logic [`ALU_REG_BITS-1:0] dest,
                                      input logic [`ALU_REG_BITS-1:0] src_a,
                                      input logic [`ALU_IMM_BITS-1:0] imm);
    instr_u u;
    u          = '0;
    u.i.is_imm = 1'b1;
    u.i.opcode = op;
    u.i.dest   = dest;
    u.i.src_a  = src_a;
    u.i.imm    = imm;
    return u;
  endfunction

  function automatic logic [`ALU_REG_BITS-1:0] pick_reg();
    return $unsigned($random(seed)) % `ALU_NREGS;
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    value_chk: assert (expected === actual) else begin
      $display("ERR %s %s expected %h actual %h", test, what, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "Mismatch in %s", test);
    end
  endtask

  // Full four-phase transfer of one instruction, mirror updated at the end
  task automatic run_instr(input string test, input instr_u ins);
    alu_op_e      op;
    logic [W-1:0] a;
    logic [W-1:0] b;
    prediction_t  p;
    logic [W-1:0] held_result;
    alu_flags_t   held_flags;
    int           n;
    int           hold;
    op = ins.r.opcode;
    a  = regs_m[ins.r.src_a];
    if (ins.r.is_imm)
      b = ins.i.imm;       // Zero extended
    else
      b = regs_m[ins.r.src_b];
    p = predict(op, a, b, flags_m.carry);
    @(negedge clk);
    instr = ins;
    req   = 1'b1;
    n     = 0;
    while (ack !== 1'b1) begin
      @(negedge clk);
      n++;
    end
    // First negedge follows the capture edge
    if (op != OP_DIV)
      check_value(test, "ack latency", 2, n - 1);
    check_value(test, "result", p.value, result);
    check_value(test, "flags", p.flags, flags);
    held_result = result;
    held_flags  = flags;
    hold        = $unsigned($random(seed)) % 6; // Back-pressure 0 to 5 cycles
    repeat (hold) begin
      @(negedge clk);
      check_value(test, "ack during hold", 1, ack);
      check_value(test, "result during hold", held_result, result);
      check_value(test, "flags during hold", held_flags, flags);
    end
    req = 1'b0;
    while (ack !== 1'b0) begin
      @(negedge clk);
    end
    if (op != OP_CMP)
      regs_m[ins.r.dest] = p.value;
    flags_m = p.flags;
  endtask

  // Run length guard
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    instr_u                   ins;
    logic [31:0]              word;
    logic [`ALU_REG_BITS-1:0] x;
    logic [`ALU_REG_BITS-1:0] y;
    logic [`ALU_REG_BITS-1:0] d;
    seed        = 32'hb155_13e1;
    cycle_count = 0;
    rst_n       = 1'b0;
    req         = 1'b0;
    instr       = '0;
    flags_m     = '0;
    for (int r = 0; r < `ALU_NREGS; r++)
      regs_m[r] = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset", "ack", 0, ack);

    // Immediate loads, then register-form read back
    for (int r = 0; r < `ALU_NREGS; r++) begin
      run_instr("load_mov", make_imm(OP_MOV, r, r, $random(seed)));
      run_instr("load_add", make_imm(OP_ADD, r, r, $random(seed)));
    end
    for (int r = 0; r < `ALU_NREGS; r++)
      run_instr("load_read", make_reg(OP_MOV, r, r, r));

    // All opcodes in turn, other fields random
    for (int i = 0; i < N_RAND; i++) begin
      word      = $random(seed);
      ins       = word[W-1:0];
      ins.r.opcode = alu_op_e'(i % 16);
      run_instr("random", ins);
    end

    // Stored carry feeds adc and sbc, cmp leaves dest alone
    for (int k = 0; k < N_ROUNDS; k++) begin
      x = pick_reg();
      y = pick_reg();
      d = pick_reg();
      run_instr("chain_not", make_reg(OP_NOT, x, x, y)); // Large operand for carries
      run_instr("chain_add", make_reg(OP_ADD, d, x, y));
      run_instr("chain_adc", make_reg(OP_ADC, d, x, y));
      run_instr("chain_sub", make_reg(OP_SUB, d, y, x));
      run_instr("chain_sbc", make_reg(OP_SBC, d, y, x));
      run_instr("chain_cmp", make_reg(OP_CMP, d, x, y));
      run_instr("chain_read", make_reg(OP_MOV, d, d, d));
    end

    // Division, every fourth one by zero
    for (int k = 0; k < N_DIV; k++) begin
      x = pick_reg();
      y = pick_reg();
      d = pick_reg();
      if (k % 4 == 0)
        run_instr("div_zero", make_imm(OP_DIV, d, x, 0));
      else
        run_instr("div", make_reg(OP_DIV, d, x, y));
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+include
hdl/alu_pkg.sv
hdl/alu_core.sv
hdl/divider_seq.sv
hdl/reg_file.sv
hdl/exec_ctrl.sv
hdl/alu_subsys_top.sv
verification/tb_clock_gen.sv
verification/alu_subsys_tb.sv

// File: Bender.yml
package:
  name: alu_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/alu_pkg.sv
      - hdl/alu_core.sv
      - hdl/divider_seq.sv
      - hdl/reg_file.sv
      - hdl/exec_ctrl.sv
      - hdl/alu_subsys_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_clock_gen.sv
      - verification/alu_subsys_tb.sv
